/* dma_read_ctrl.sv */
// read stage of the accelerator
// fetches matrix A then matrix B as one burst each
// and passes every row beat on to the compute stage

`timescale 1ns/1ps

module dma_read_ctrl
    import mm_accel_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_i,
    input  addr_t      mat_a_addr_i,
    input  addr_t      mat_b_addr_i,
    output logic       ar_valid_o,
    input  logic       ar_ready_i,
    output addr_t      ar_addr_o,
    input  logic       r_valid_i,
    output logic       r_ready_o,
    input  bus_word_u  r_data_i,
    input  logic       r_last_i,
    mm_stream_if.src   opnd_o,
    input  logic       run_done_i
);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_ADDR_A = 3'd1;
    localparam logic [2:0] S_DATA_A = 3'd2;
    localparam logic [2:0] S_ADDR_B = 3'd3;
    localparam logic [2:0] S_DATA_B = 3'd4;
    localparam logic [2:0] S_WAIT   = 3'd5;

    logic [2:0] state_q;
    logic [2:0] state_d;
    addr_t      a_addr_q;
    addr_t      b_addr_q;
    logic       in_burst;
    logic       last_fire;

    assign in_burst = (state_q == S_DATA_A) || (state_q == S_DATA_B);

    // address phase straight from the state
    assign ar_valid_o = (state_q == S_ADDR_A) || (state_q == S_ADDR_B);
    assign ar_addr_o  = (state_q == S_ADDR_B) ? b_addr_q : a_addr_q;

    // row beats flow through, memory sees the engine's ready
    assign r_ready_o    = in_burst & opnd_o.ready;
    assign opnd_o.valid = in_burst & r_valid_i;
    assign opnd_o.data  = r_data_i;
    // only the end of B closes the operand transfer
    assign opnd_o.last  = (state_q == S_DATA_B) & r_last_i;

    assign last_fire = r_valid_i & r_ready_o & r_last_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (start_i) state_d = S_ADDR_A;
            end
            S_ADDR_A: begin
                if (ar_ready_i) state_d = S_DATA_A;
            end
            S_DATA_A: begin
                if (last_fire) state_d = S_ADDR_B;
            end
            S_ADDR_B: begin
                if (ar_ready_i) state_d = S_DATA_B;
            end
            S_DATA_B: begin
                if (last_fire) state_d = S_WAIT;
            end
            S_WAIT: begin
                // stay busy until the writes are done, start is ignored here
                if (run_done_i) state_d = S_IDLE;
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // base addresses captured at start, stable for the whole run
    always_ff @(posedge clk) begin
        if ((state_q == S_IDLE) && start_i) begin
            a_addr_q <= mat_a_addr_i;
            b_addr_q <= mat_b_addr_i;
        end
    end

endmodule

/* dma_write_ctrl.sv */
// write stage of the accelerator
// registered slice that turns each result into an addressed write
// pulses done after the final write is accepted

`timescale 1ns/1ps

`include "mm_accel_consts.svh"

module dma_write_ctrl
    import mm_accel_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  addr_t      mat_c_addr_i,
    mm_stream_if.snk   res_i,
    output logic       w_valid_o,
    input  logic       w_ready_i,
    output addr_t      w_addr_o,
    output bus_word_u  w_data_o,
    output logic       done_o
);

    localparam int CNT_W = $clog2(`MM_SA_WIDTH * `MM_SA_WIDTH);

    // row-major index of the next result
    logic [CNT_W-1:0] res_cnt_q;
    // held write is the last of the run
    logic             last_q;
    logic             res_fire;
    logic             w_fire;

    assign w_fire      = w_valid_o & w_ready_i;
    // free slot, or the held write leaves this cycle
    assign res_i.ready = !w_valid_o || w_ready_i;
    assign res_fire    = res_i.valid & res_i.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_valid_o <= 1'b0;
            last_q    <= 1'b0;
            res_cnt_q <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= w_fire & last_q;
            if (res_fire) begin
                w_valid_o <= 1'b1;
                last_q    <= res_i.last;
                // back to index 0 for the next run
                res_cnt_q <= res_i.last ? '0 : res_cnt_q + 1'b1;
            end else if (w_fire) begin
                w_valid_o <= 1'b0;
                last_q    <= 1'b0;
            end
        end
    end

    // word address, four bytes per result
    always_ff @(posedge clk) begin
        if (res_fire) begin
            w_addr_o <= mat_c_addr_i + (addr_t'(res_cnt_q) << 2);
            w_data_o <= res_i.data;
        end
    end

endmodule

/* flist.f */
+incdir+.
mm_accel_pkg.sv
mm_stream_if.sv
dma_read_ctrl.sv
mm_engine.sv
dma_write_ctrl.sv
mm_accel_top.sv
mm_accel_asserts.sv
tb_mm_accel.sv

/* mm_accel_asserts.sv */
// protocol checks on the accelerator's memory ports
// bound into the top level

`timescale 1ns/1ps

module mm_accel_asserts
    import mm_accel_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      ar_valid_i,
    input logic      ar_ready_i,
    input addr_t     ar_addr_i,
    input logic      w_valid_i,
    input logic      w_ready_i,
    input addr_t     w_addr_i,
    input bus_word_u w_data_i,
    input logic      done_i
);

    // stalled read address keeps valid and address
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
        else $error("read address dropped or changed while stalled");

    // stalled write keeps valid, address and data
    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_addr_i) && $stable(w_data_i))
        else $error("write dropped or changed while stalled");

    // done lasts one cycle
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |=> !done_i)
        else $error("done held for more than one cycle");

    // no new burst in the done cycle
    a_done_no_ar: assert property (@(posedge clk) disable iff (!rst_n)
        !(done_i && ar_valid_i))
        else $error("read address issued together with done");

endmodule

bind mm_accel_top mm_accel_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .ar_addr_i  (ar_addr_o),
    .w_valid_i  (w_valid_o),
    .w_ready_i  (w_ready_i),
    .w_addr_i   (w_addr_o),
    .w_data_i   (w_data_o),
    .done_i     (done_o)
);

/* mm_accel_consts.svh */
// matrix-multiply accelerator constants
// bus, element and address widths plus the matrix side

`ifndef MM_ACCEL_CONSTS_SVH
`define MM_ACCEL_CONSTS_SVH

// matrix side, also the read burst length in beats
`define MM_SA_WIDTH 4

// signed matrix element
`define MM_ELEM_W 8

// memory data bus, one matrix row per beat
`define MM_BUS_W 32

// dot product accumulator
`define MM_ACC_W 32

// byte addresses on the memory side
`define MM_ADDR_W 32

`endif

/* mm_accel_pkg.sv */
// matrix-multiply accelerator types
// element, accumulator, address and the decoded bus word

`include "mm_accel_consts.svh"

package mm_accel_pkg;

    // one matrix element, two's complement
    typedef logic signed [`MM_ELEM_W-1:0] elem_t;

    // result of one row by column product
    typedef logic signed [`MM_ACC_W-1:0] acc_t;

    // byte address
    typedef logic [`MM_ADDR_W-1:0] addr_t;

    // bus word, seen as a raw word or as one row of elements
    // lane 0 is the low byte, so column j of a row sits in lane j
    typedef union packed {
        logic [`MM_BUS_W-1:0]         raw;
        elem_t [`MM_SA_WIDTH-1:0]     lanes;
    } bus_word_u;

endpackage

/* mm_accel_top.sv */
// matrix-multiply accelerator top level
// read stage, compute stage and write stage in a row
// plain memory and configuration ports

`timescale 1ns/1ps

module mm_accel_top
    import mm_accel_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_i,
    input  addr_t      mat_a_addr_i,
    input  addr_t      mat_b_addr_i,
    input  addr_t      mat_c_addr_i,
    output logic       done_o,
    output logic       ar_valid_o,
    input  logic       ar_ready_i,
    output addr_t      ar_addr_o,
    input  logic       r_valid_i,
    output logic       r_ready_o,
    input  bus_word_u  r_data_i,
    input  logic       r_last_i,
    output logic       w_valid_o,
    input  logic       w_ready_i,
    output addr_t      w_addr_o,
    output bus_word_u  w_data_o
);

    // A rows then B rows
    mm_stream_if opnd_s ();
    // C accumulators, row-major
    mm_stream_if res_s ();

    dma_read_ctrl u_read (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .ar_valid_o   (ar_valid_o),
        .ar_ready_i   (ar_ready_i),
        .ar_addr_o    (ar_addr_o),
        .r_valid_i    (r_valid_i),
        .r_ready_o    (r_ready_o),
        .r_data_i     (r_data_i),
        .r_last_i     (r_last_i),
        .opnd_o       (opnd_s.src),
        // done re-arms the read stage
        .run_done_i   (done_o)
    );

    mm_engine u_engine (
        .clk    (clk),
        .rst_n  (rst_n),
        .opnd_i (opnd_s.snk),
        .res_o  (res_s.src)
    );

    dma_write_ctrl u_write (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_c_addr_i (mat_c_addr_i),
        .res_i        (res_s.snk),
        .w_valid_o    (w_valid_o),
        .w_ready_i    (w_ready_i),
        .w_addr_o     (w_addr_o),
        .w_data_o     (w_data_o),
        .done_o       (done_o)
    );

endmodule

/* mm_engine.sv */
// compute stage of the accelerator
// buffers the A and B rows, then streams C = A x B
// one accumulator per transfer in row-major order

`timescale 1ns/1ps

`include "mm_accel_consts.svh"

module mm_engine
    import mm_accel_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    mm_stream_if.snk  opnd_i,
    mm_stream_if.src  res_o
);

    localparam int IDX_W = $clog2(`MM_SA_WIDTH);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`MM_SA_WIDTH - 1);

    // operand buffers, fully rewritten every run
    elem_t a_q [`MM_SA_WIDTH][`MM_SA_WIDTH];
    elem_t b_q [`MM_SA_WIDTH][`MM_SA_WIDTH];

    logic             computing_q;
    // top bit picks B, low bits pick the row
    logic [IDX_W:0]   beat_q;
    logic [IDX_W-1:0] row_q;
    logic [IDX_W-1:0] col_q;
    logic             load_fire;
    logic             res_fire;
    logic             last_res;
    acc_t             dot;

    // accept rows only in the loading phase
    assign opnd_i.ready = !computing_q;
    assign load_fire    = opnd_i.valid & opnd_i.ready;
    assign res_fire     = res_o.valid & res_o.ready;
    assign last_res     = (row_q == LAST_IDX) && (col_q == LAST_IDX);

    // counters only move on a transfer
    // so the result stays put on res_o while stalled
    assign res_o.valid    = computing_q;
    assign res_o.last     = last_res;
    assign res_o.data.raw = dot;

    // row of A times column of B
    always_comb begin
        dot = '0;
        for (int k = 0; k < `MM_SA_WIDTH; k++) begin
            dot = dot + acc_t'(a_q[row_q][k]) * acc_t'(b_q[k][col_q]);
        end
    end

    // one row per beat, split into lanes
    always_ff @(posedge clk) begin
        if (load_fire) begin
            for (int j = 0; j < `MM_SA_WIDTH; j++) begin
                if (beat_q[IDX_W]) begin
                    b_q[beat_q[IDX_W-1:0]][j] <= opnd_i.data.lanes[j];
                end else begin
                    a_q[beat_q[IDX_W-1:0]][j] <= opnd_i.data.lanes[j];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            computing_q <= 1'b0;
            beat_q      <= '0;
            row_q       <= '0;
            col_q       <= '0;
        end else if (!computing_q) begin
            if (load_fire) begin
                beat_q <= beat_q + 1'b1;
                // B row 3 in, results start next cycle
                if (opnd_i.last) begin
                    computing_q <= 1'b1;
                    beat_q      <= '0;
                end
            end
        end else if (res_fire) begin
            // row and column wrap back to zero after the 16th
            col_q <= col_q + 1'b1;
            if (col_q == LAST_IDX) begin
                row_q <= row_q + 1'b1;
            end
            if (last_res) begin
                computing_q <= 1'b0;
            end
        end
    end

endmodule

/* mm_patterns.hex */
// 24 words per test: A rows 0-3, B rows 0-3 (lane j = column j, lane 0 low byte)
// then the 16 expected C accumulators in row-major order
// test 1
04030201
fe0500ff
0102fd07
03fa0400
0300ff02
00fe0101
020104fd
ff020005
0000000f
0000000d
00000007
00000005
ffffffe5
00000015
00000001
00000009
0000000a
fffffffe
0000000a
00000018
00000025
ffffffec
fffffff8
fffffff1
// test 2
fb0a807f
03030303
0ce7329c
0100ff00
02000180
0006ff7f
64f90002
ce0409fe
ffff811e
000000d2
fffffca6
000005e0
fffffffd
0000001b
00000009
0000009c
00004a84
ffffffd6
0000020b
fffff31c
ffffff7f
0000000a
fffffffe
ffffffce

/* mm_stream_if.sv */
// valid/ready stream between pipeline stages
// a beat moves on a clock edge with valid and ready both high

`timescale 1ns/1ps

interface mm_stream_if import mm_accel_pkg::*; ();

    logic      valid;
    logic      ready;
    bus_word_u data;
    // marks the final beat of a matrix transfer
    logic      last;

    // producer side
    modport src (output valid, output data, output last, input ready);

    // consumer side
    modport snk (input valid, input data, input last, output ready);

endinterface

/* run_sim.sh */
#!/bin/sh
# build and run the accelerator testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mm_accel -f flist.f -o Vtb_mm_accel
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mm_accel > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* tb_mm_accel.sv */
// testbench for the matrix-multiply accelerator
// memory model with random stalls, operands and results from a hex file

`timescale 1ns/1ps

`include "mm_accel_consts.svh"

module tb_mm_accel import mm_accel_pkg::*; ();

    localparam int N_RES     = `MM_SA_WIDTH * `MM_SA_WIDTH;
    localparam int PAT_WORDS = 2 * `MM_SA_WIDTH + N_RES;
    localparam int TIMEOUT   = 3000;

    logic      clk = 1'b0;
    logic      rst_n = 1'b0;
    logic      start_i = 1'b0;
    addr_t     mat_a_addr_i = '0;
    addr_t     mat_b_addr_i = '0;
    addr_t     mat_c_addr_i = '0;
    logic      done_o;
    logic      ar_valid_o;
    logic      ar_ready_i = 1'b0;
    addr_t     ar_addr_o;
    logic      r_valid_i = 1'b0;
    logic      r_ready_o;
    bus_word_u r_data_i = '0;
    logic      r_last_i = 1'b0;
    logic      w_valid_o;
    logic      w_ready_i = 1'b0;
    addr_t     w_addr_o;
    bus_word_u w_data_o;

    // two tests back to back in the pattern array
    logic [31:0] pat [0:2*PAT_WORDS-1];
    // word-addressed memory, byte address bits 9:2
    logic [31:0] mem [0:255];
    logic        wr_seen [0:255];
    integer      seed = 32'hcdfb;
    int          errors = 0;
    string       test_name = "reset";
    int          pat_base = 0;
    addr_t       a_base = '0;
    addr_t       b_base = '0;
    addr_t       c_base = '0;
    int          burst_cnt = 0;
    int          wr_count = 0;
    int          done_cnt = 0;
    logic        timed_out = 1'b0;
    // open read burst
    logic        rd_active = 1'b0;
    logic [7:0]  rd_word = '0;
    int          rd_beat = 0;

    mm_accel_top DUT (.*);

    initial begin
        forever #50 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("ERROR %s: %s", test_name, msg);
        errors++;
    endtask

    task automatic check_word(input string what, input bus_word_u exp, input bus_word_u act);
        if (act !== exp) begin
            $display("FAILED %s %s expected %h actual %h", test_name, what, exp.raw, act.raw);
            errors++;
        end
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("FAILED %s %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("FAILED %s %s expected %0d actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    // memory model, samples handshakes and drives the next cycle
    always @(posedge clk) begin : mem_model
        bus_word_u exp_w;
        if (!rst_n) begin
            ar_ready_i <= 1'b0;
            r_valid_i  <= 1'b0;
            w_ready_i  <= 1'b0;
        end else begin
            if (r_valid_i && r_ready_o) begin
                rd_word = rd_word + 8'd1;
                rd_beat = rd_beat + 1;
                if (rd_beat == `MM_SA_WIDTH) begin
                    rd_active = 1'b0;
                end
            end
            // first burst is A, second is B, nothing after
            if (ar_valid_o && ar_ready_i) begin
                if (burst_cnt == 0) begin
                    check_addr("burst A address", a_base, ar_addr_o);
                end else if (burst_cnt == 1) begin
                    check_addr("burst B address", b_base, ar_addr_o);
                end else begin
                    report_error("extra read burst issued");
                end
                burst_cnt++;
                rd_active = 1'b1;
                rd_word   = ar_addr_o[9:2];
                rd_beat   = 0;
            end
            // a stalled beat stays put
            if (!r_valid_i || r_ready_o) begin
                r_valid_i    <= rd_active && (($random(seed) & 3) != 0);
                r_data_i.raw <= mem[rd_word];
                r_last_i     <= (rd_beat == `MM_SA_WIDTH - 1);
            end
            // writes arrive in row-major order
            if (w_valid_o && w_ready_i) begin
                if (wr_count >= N_RES) begin
                    report_error("more writes than results");
                end else begin
                    exp_w.raw = pat[pat_base + 2 * `MM_SA_WIDTH + wr_count];
                    check_addr("write address", c_base + addr_t'(4 * wr_count), w_addr_o);
                    check_word("write data", exp_w, w_data_o);
                end
                if (wr_seen[w_addr_o[9:2]]) begin
                    report_error("same address written twice");
                end
                wr_seen[w_addr_o[9:2]] = 1'b1;
                mem[w_addr_o[9:2]]     = w_data_o.raw;
                wr_count++;
            end
            if (done_o) begin
                done_cnt++;
                if (wr_count != N_RES) begin
                    report_error("done before the last write");
                end
            end
            ar_ready_i <= ($random(seed) & 3) != 0;
            w_ready_i  <= ($random(seed) & 3) != 0;
        end
    end

    // one full run, with a stray start once the writes have begun
    task automatic run_test(input int idx, input addr_t a_addr, input addr_t b_addr,
                            input addr_t c_addr);
        int        cycles;
        bus_word_u exp_w;
        bus_word_u got_w;
        test_name = $sformatf("run %0d", idx + 1);
        pat_base  = idx * PAT_WORDS;
        a_base    = a_addr;
        b_base    = b_addr;
        c_base    = c_addr;
        burst_cnt = 0;
        wr_count  = 0;
        done_cnt  = 0;
        for (int i = 0; i < 256; i++) begin
            wr_seen[i] = 1'b0;
        end
        for (int i = 0; i < `MM_SA_WIDTH; i++) begin
            mem[int'(a_addr[9:2]) + i] = pat[pat_base + i];
            mem[int'(b_addr[9:2]) + i] = pat[pat_base + `MM_SA_WIDTH + i];
        end
        @(posedge clk);
        mat_a_addr_i <= a_addr;
        mat_b_addr_i <= b_addr;
        mat_c_addr_i <= c_addr;
        start_i      <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        cycles = 0;
        while (wr_count == 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (wr_count == 0) begin
            report_error("timed out waiting for the first write");
            timed_out = 1'b1;
            return;
        end
        // read stage is busy here, this start must be ignored
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        cycles = 0;
        while (done_cnt == 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (done_cnt == 0) begin
            report_error("timed out waiting for done");
            timed_out = 1'b1;
            return;
        end
        // quiet cycles to catch a late burst or second done
        repeat (4) @(posedge clk);
        check_count("read bursts", 2, burst_cnt);
        check_count("writes", N_RES, wr_count);
        check_count("done pulses", 1, done_cnt);
        for (int i = 0; i < N_RES; i++) begin
            exp_w.raw = pat[pat_base + 2 * `MM_SA_WIDTH + i];
            got_w.raw = mem[int'(c_addr[9:2]) + i];
            check_word("C in memory", exp_w, got_w);
        end
    endtask

    initial begin : main
        $readmemh("mm_patterns.hex", pat);
        // background fill, unique per word
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5a00_0000 ^ (32'(i) * 32'h0001_0203);
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        run_test(0, 32'h0000_0100, 32'h0000_0180, 32'h0000_0200);
        // other bases, so stale buffers or addresses would show
        if (!timed_out) begin
            run_test(1, 32'h0000_0040, 32'h0000_00c0, 32'h0000_0300);
        end
        $display("checks done, %0d error(s)", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
